// File: hdl/rvv_alu_macros.svh
`ifndef RVV_ALU_MACROS_SVH
`define RVV_ALU_MACROS_SVH

// vector register width in bits
`define VLEN 128

// reorder buffer tag width
`define ROB_DEPTH_WIDTH 3

// wide enough to index every bit of a vector register
`define VSTART_WIDTH 7

// reservation queue entries
`define RS_DEPTH 4

`endif

// File: hdl/rvv_alu_pkg.sv
package rvv_alu_pkg;

  // operand category
  typedef enum logic [2:0] {
    OPIVV = 3'b000,
    OPMVV = 3'b010
  } funct3_e;

  // operation codes
  typedef enum logic [5:0] {
    // integer element logic
    VAND   = 6'b001001,
    VOR    = 6'b001010,
    VXOR   = 6'b001011,
    // mask register logic
    VMANDN = 6'b011000,
    VMAND  = 6'b011001,
    VMOR   = 6'b011010,
    VMXOR  = 6'b011011,
    VMORN  = 6'b011100,
    VMNAND = 6'b011101,
    VMNOR  = 6'b011110,
    VMXNOR = 6'b011111
  } funct6_e;

  // selected element width, vtype encoding
  typedef enum logic [1:0] {
    SEW8  = 2'b00,
    SEW16 = 2'b01,
    SEW32 = 2'b10
  } vsew_e;

endpackage

// File: hdl/rvv_alu_csr.sv
`include "rvv_alu_macros.svh"

module rvv_alu_csr
  import rvv_alu_pkg::*;
(
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     csr_write,
  input  logic [`VSTART_WIDTH-1:0] csr_vstart,
  input  vsew_e                    csr_vsew,
  input  logic                     issue_valid,
  output logic [`VSTART_WIDTH-1:0] vstart,
  output vsew_e                    vsew
);

  // start index, returns to zero once a uop has issued
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      vstart <= '0;
    end else if (csr_write) begin
      // an explicit write wins over the clear
      vstart <= csr_vstart;
    end else if (issue_valid) begin
      vstart <= '0;
    end
  end

  // element width only changes on a write
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      vsew <= SEW8;
    end else if (csr_write) begin
      vsew <= csr_vsew;
    end
  end

endmodule

// File: hdl/rvv_alu_rs.sv
`include "rvv_alu_macros.svh"

module rvv_alu_rs
  import rvv_alu_pkg::*;
(
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        uop_valid,
  input  logic [`ROB_DEPTH_WIDTH-1:0] uop_rob_entry,
  input  funct3_e                     uop_funct3,
  input  funct6_e                     uop_funct6,
  input  logic                        uop_vm,
  input  logic [`VLEN-1:0]            uop_v0_data,
  input  logic [`VLEN-1:0]            uop_vd_data,
  input  logic [`VLEN-1:0]            uop_vs1_data,
  input  logic [`VLEN-1:0]            uop_vs2_data,
  output logic                        rs_full,
  output logic                        issue_valid,
  output logic [`ROB_DEPTH_WIDTH-1:0] issue_rob_entry,
  output funct3_e                     issue_funct3,
  output funct6_e                     issue_funct6,
  output logic                        issue_vm,
  output logic [`VLEN-1:0]            issue_v0_data,
  output logic [`VLEN-1:0]            issue_vd_data,
  output logic [`VLEN-1:0]            issue_vs1_data,
  output logic [`VLEN-1:0]            issue_vs2_data
);

  localparam int PTR_W = $clog2(`RS_DEPTH);
  localparam int CNT_W = $clog2(`RS_DEPTH + 1);

  logic [`ROB_DEPTH_WIDTH-1:0] rob_mem [`RS_DEPTH];
  funct3_e                     funct3_mem [`RS_DEPTH];
  funct6_e                     funct6_mem [`RS_DEPTH];
  logic                        vm_mem [`RS_DEPTH];
  logic [`VLEN-1:0]            v0_mem [`RS_DEPTH];
  logic [`VLEN-1:0]            vd_mem [`RS_DEPTH];
  logic [`VLEN-1:0]            vs1_mem [`RS_DEPTH];
  logic [`VLEN-1:0]            vs2_mem [`RS_DEPTH];

  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             push;
  logic             pop;

  assign rs_full     = (count == CNT_W'(`RS_DEPTH));
  assign issue_valid = (count != '0);
  assign push        = uop_valid & ~rs_full;
  // head leaves every cycle the queue holds something
  assign pop         = issue_valid;

  always_ff @(posedge clk) begin
    if (push) begin
      rob_mem[wr_ptr]    <= uop_rob_entry;
      funct3_mem[wr_ptr] <= uop_funct3;
      funct6_mem[wr_ptr] <= uop_funct6;
      vm_mem[wr_ptr]     <= uop_vm;
      v0_mem[wr_ptr]     <= uop_v0_data;
      vd_mem[wr_ptr]     <= uop_vd_data;
      vs1_mem[wr_ptr]    <= uop_vs1_data;
      vs2_mem[wr_ptr]    <= uop_vs2_data;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == PTR_W'(`RS_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(`RS_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      // simultaneous push and pop leaves count unchanged
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  assign issue_rob_entry = rob_mem[rd_ptr];
  assign issue_funct3    = funct3_mem[rd_ptr];
  assign issue_funct6    = funct6_mem[rd_ptr];
  assign issue_vm        = vm_mem[rd_ptr];
  assign issue_v0_data   = v0_mem[rd_ptr];
  assign issue_vd_data   = vd_mem[rd_ptr];
  assign issue_vs1_data  = vs1_mem[rd_ptr];
  assign issue_vs2_data  = vs2_mem[rd_ptr];

endmodule

// File: hdl/rvv_alu_unit_mask.sv
`include "rvv_alu_macros.svh"

module rvv_alu_unit_mask
  import rvv_alu_pkg::*;
(
  input  logic                     issue_valid,
  input  funct3_e                  issue_funct3,
  input  funct6_e                  issue_funct6,
  input  logic                     issue_vm,
  input  logic [`VLEN-1:0]         issue_vd_data,
  input  logic [`VLEN-1:0]         issue_vs1_data,
  input  logic [`VLEN-1:0]         issue_vs2_data,
  input  logic [`VSTART_WIDTH-1:0] vstart,
  output logic                     mask_hit,
  output logic [`VLEN-1:0]         mask_w_data
);

  logic             is_mask_op;
  logic [`VLEN-1:0] mask_result;

  // decode the OPMVV mask-register group
  always_comb begin
    is_mask_op = 1'b0;
    if (issue_valid && issue_funct3 == OPMVV) begin
      case (issue_funct6)
        VMANDN,
        VMAND,
        VMOR,
        VMXOR,
        VMORN,
        VMNAND,
        VMNOR,
        VMXNOR:  is_mask_op = 1'b1;
        default: is_mask_op = 1'b0;
      endcase
    end
  end

  // these ops are only defined unmasked
  assign mask_hit = is_mask_op & issue_vm;

  // bitwise op over the whole register, vs2 is the first operand
  always_comb begin
    case (issue_funct6)
      VMANDN:  mask_result = issue_vs2_data & ~issue_vs1_data;
      VMAND:   mask_result = issue_vs2_data & issue_vs1_data;
      VMOR:    mask_result = issue_vs2_data | issue_vs1_data;
      VMXOR:   mask_result = issue_vs2_data ^ issue_vs1_data;
      VMORN:   mask_result = issue_vs2_data | ~issue_vs1_data;
      VMNAND:  mask_result = ~(issue_vs2_data & issue_vs1_data);
      VMNOR:   mask_result = ~(issue_vs2_data | issue_vs1_data);
      VMXNOR:  mask_result = ~(issue_vs2_data ^ issue_vs1_data);
      default: mask_result = '0;
    endcase
  end

  // prefix below vstart keeps the old destination bits
  always_comb begin
    mask_w_data = '0;
    if (mask_hit) begin
      for (int i = 0; i < `VLEN; i++) begin
        if (i < int'(vstart)) begin
          mask_w_data[i] = issue_vd_data[i];
        end else begin
          mask_w_data[i] = mask_result[i];
        end
      end
    end
  end

endmodule

// File: hdl/rvv_alu_unit_logic.sv
`include "rvv_alu_macros.svh"

module rvv_alu_unit_logic
  import rvv_alu_pkg::*;
(
  input  logic                     issue_valid,
  input  funct3_e                  issue_funct3,
  input  funct6_e                  issue_funct6,
  input  logic                     issue_vm,
  input  logic [`VLEN-1:0]         issue_v0_data,
  input  logic [`VLEN-1:0]         issue_vd_data,
  input  logic [`VLEN-1:0]         issue_vs1_data,
  input  logic [`VLEN-1:0]         issue_vs2_data,
  input  logic [`VSTART_WIDTH-1:0] vstart,
  input  vsew_e                    vsew,
  output logic                     logic_hit,
  output logic [`VLEN-1:0]         logic_w_data
);

  logic             is_logic_op;
  logic [2:0]       sew_shift;
  logic [`VLEN-1:0] logic_result;

  // decode vand, vor and vxor in the vector-vector form
  always_comb begin
    is_logic_op = 1'b0;
    if (issue_valid && issue_funct3 == OPIVV) begin
      case (issue_funct6)
        VAND,
        VOR,
        VXOR:    is_logic_op = 1'b1;
        default: is_logic_op = 1'b0;
      endcase
    end
  end

  assign logic_hit = is_logic_op;

  // log2 of the element width in bits
  always_comb begin
    case (vsew)
      SEW16:   sew_shift = 3'd4;
      SEW32:   sew_shift = 3'd5;
      default: sew_shift = 3'd3;
    endcase
  end

  // element boundaries do not matter for bitwise ops
  always_comb begin
    case (issue_funct6)
      VAND:    logic_result = issue_vs2_data & issue_vs1_data;
      VOR:     logic_result = issue_vs2_data | issue_vs1_data;
      VXOR:    logic_result = issue_vs2_data ^ issue_vs1_data;
      default: logic_result = '0;
    endcase
  end

  // per bit, find the owning element and apply vstart and v0 masking
  always_comb begin
    int elem;
    elem         = 0;
    logic_w_data = '0;
    if (logic_hit) begin
      for (int b = 0; b < `VLEN; b++) begin
        elem = b >> sew_shift;
        // mask-undisturbed, inactive elements keep vd
        if (elem < int'(vstart) || (!issue_vm && !issue_v0_data[elem])) begin
          logic_w_data[b] = issue_vd_data[b];
        end else begin
          logic_w_data[b] = logic_result[b];
        end
      end
    end
  end

endmodule

// File: hdl/rvv_alu_rob_wb.sv
`include "rvv_alu_macros.svh"

module rvv_alu_rob_wb (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        issue_valid,
  input  logic [`ROB_DEPTH_WIDTH-1:0] issue_rob_entry,
  input  logic                        mask_hit,
  input  logic [`VLEN-1:0]            mask_w_data,
  input  logic                        logic_hit,
  input  logic [`VLEN-1:0]            logic_w_data,
  output logic                        result_valid,
  output logic [`ROB_DEPTH_WIDTH-1:0] result_rob_entry,
  output logic [`VLEN-1:0]            result_w_data,
  output logic                        result_w_valid,
  output logic                        result_ignore_vta
);

  logic [`VLEN-1:0] sel_w_data;

  // at most one unit claims a uop
  always_comb begin
    if (mask_hit) begin
      sel_w_data = mask_w_data;
    end else if (logic_hit) begin
      sel_w_data = logic_w_data;
    end else begin
      sel_w_data = '0;
    end
  end

  // one pulse per issued uop, supported or not
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      result_valid <= 1'b0;
    end else begin
      result_valid <= issue_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (issue_valid) begin
      result_rob_entry  <= issue_rob_entry;
      result_w_data     <= sel_w_data;
      // unsupported uops retire without a register write
      result_w_valid    <= mask_hit | logic_hit;
      result_ignore_vta <= mask_hit;
    end
  end

endmodule

// File: hdl/rvv_alu_top.sv
`include "rvv_alu_macros.svh"

module rvv_alu_top
  import rvv_alu_pkg::*;
(
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        uop_valid,
  input  logic [`ROB_DEPTH_WIDTH-1:0] uop_rob_entry,
  input  funct3_e                     uop_funct3,
  input  funct6_e                     uop_funct6,
  input  logic                        uop_vm,
  input  logic [`VLEN-1:0]            uop_v0_data,
  input  logic [`VLEN-1:0]            uop_vd_data,
  input  logic [`VLEN-1:0]            uop_vs1_data,
  input  logic [`VLEN-1:0]            uop_vs2_data,
  input  logic                        csr_write,
  input  logic [`VSTART_WIDTH-1:0]    csr_vstart,
  input  vsew_e                       csr_vsew,
  output logic                        rs_full,
  output logic                        result_valid,
  output logic [`ROB_DEPTH_WIDTH-1:0] result_rob_entry,
  output logic [`VLEN-1:0]            result_w_data,
  output logic                        result_w_valid,
  output logic                        result_ignore_vta
);

  // head of the queue, shared by both units
  logic                        issue_valid;
  logic [`ROB_DEPTH_WIDTH-1:0] issue_rob_entry;
  funct3_e                     issue_funct3;
  funct6_e                     issue_funct6;
  logic                        issue_vm;
  logic [`VLEN-1:0]            issue_v0_data;
  logic [`VLEN-1:0]            issue_vd_data;
  logic [`VLEN-1:0]            issue_vs1_data;
  logic [`VLEN-1:0]            issue_vs2_data;

  logic [`VSTART_WIDTH-1:0]    vstart;
  vsew_e                       vsew;

  logic                        mask_hit;
  logic [`VLEN-1:0]            mask_w_data;
  logic                        logic_hit;
  logic [`VLEN-1:0]            logic_w_data;

  rvv_alu_rs u_rs (
    .clk             (clk),
    .rst_n           (rst_n),
    .uop_valid       (uop_valid),
    .uop_rob_entry   (uop_rob_entry),
    .uop_funct3      (uop_funct3),
    .uop_funct6      (uop_funct6),
    .uop_vm          (uop_vm),
    .uop_v0_data     (uop_v0_data),
    .uop_vd_data     (uop_vd_data),
    .uop_vs1_data    (uop_vs1_data),
    .uop_vs2_data    (uop_vs2_data),
    .rs_full         (rs_full),
    .issue_valid     (issue_valid),
    .issue_rob_entry (issue_rob_entry),
    .issue_funct3    (issue_funct3),
    .issue_funct6    (issue_funct6),
    .issue_vm        (issue_vm),
    .issue_v0_data   (issue_v0_data),
    .issue_vd_data   (issue_vd_data),
    .issue_vs1_data  (issue_vs1_data),
    .issue_vs2_data  (issue_vs2_data)
  );

  rvv_alu_csr u_csr (
    .clk         (clk),
    .rst_n       (rst_n),
    .csr_write   (csr_write),
    .csr_vstart  (csr_vstart),
    .csr_vsew    (csr_vsew),
    .issue_valid (issue_valid),
    .vstart      (vstart),
    .vsew        (vsew)
  );

  rvv_alu_unit_mask u_unit_mask (
    .issue_valid    (issue_valid),
    .issue_funct3   (issue_funct3),
    .issue_funct6   (issue_funct6),
    .issue_vm       (issue_vm),
    .issue_vd_data  (issue_vd_data),
    .issue_vs1_data (issue_vs1_data),
    .issue_vs2_data (issue_vs2_data),
    .vstart         (vstart),
    .mask_hit       (mask_hit),
    .mask_w_data    (mask_w_data)
  );

  rvv_alu_unit_logic u_unit_logic (
    .issue_valid    (issue_valid),
    .issue_funct3   (issue_funct3),
    .issue_funct6   (issue_funct6),
    .issue_vm       (issue_vm),
    .issue_v0_data  (issue_v0_data),
    .issue_vd_data  (issue_vd_data),
    .issue_vs1_data (issue_vs1_data),
    .issue_vs2_data (issue_vs2_data),
    .vstart         (vstart),
    .vsew           (vsew),
    .logic_hit      (logic_hit),
    .logic_w_data   (logic_w_data)
  );

  rvv_alu_rob_wb u_rob_wb (
    .clk               (clk),
    .rst_n             (rst_n),
    .issue_valid       (issue_valid),
    .issue_rob_entry   (issue_rob_entry),
    .mask_hit          (mask_hit),
    .mask_w_data       (mask_w_data),
    .logic_hit         (logic_hit),
    .logic_w_data      (logic_w_data),
    .result_valid      (result_valid),
    .result_rob_entry  (result_rob_entry),
    .result_w_data     (result_w_data),
    .result_w_valid    (result_w_valid),
    .result_ignore_vta (result_ignore_vta)
  );

endmodule

// File: verif/tb_rvv_alu_ref.svh
`ifndef TB_RVV_ALU_REF_SVH
`define TB_RVV_ALU_REF_SVH

// expected word is {rob_entry, w_valid, ignore_vta, w_data}
localparam int EXP_W = `ROB_DEPTH_WIDTH + 2 + `VLEN;

// galois lfsr, x^32 + x^22 + x^2 + x + 1
function automatic logic [31:0] lfsr_next(input logic [31:0] state);
  if (state[0]) begin
    return (state >> 1) ^ 32'h8020_0003;
  end
  return state >> 1;
endfunction

// truth table indexed by {vs2 bit, vs1 bit}
function automatic logic [3:0] op_table(input funct6_e f6);
  case (f6)
    VAND, VMAND: return 4'b1000;
    VOR, VMOR:   return 4'b1110;
    VXOR, VMXOR: return 4'b0110;
    VMANDN:      return 4'b0100;
    VMORN:       return 4'b1101;
    VMNAND:      return 4'b0111;
    VMNOR:       return 4'b0001;
    VMXNOR:      return 4'b1001;
    default:     return 4'b0000;
  endcase
endfunction

function automatic logic [EXP_W-1:0] expected_result(
  input logic [`ROB_DEPTH_WIDTH-1:0] rob_entry,
  input funct3_e                     f3,
  input funct6_e                     f6,
  input logic                        vm,
  input logic [`VLEN-1:0]            v0,
  input logic [`VLEN-1:0]            vd,
  input logic [`VLEN-1:0]            vs1,
  input logic [`VLEN-1:0]            vs2,
  input int                          vstart,
  input vsew_e                       sew
);
  logic [3:0]       tt;
  logic [`VLEN-1:0] data;
  logic             is_mask;
  logic             is_elem;
  int               width;
  int               idx;
  tt      = op_table(f6);
  data    = '0;
  is_mask = (f3 == OPMVV) && (f6 inside {VMANDN, VMAND, VMOR, VMXOR,
                                         VMORN, VMNAND, VMNOR, VMXNOR}) && vm;
  is_elem = (f3 == OPIVV) && (f6 inside {VAND, VOR, VXOR});
  case (sew)
    SEW16:   width = 16;
    SEW32:   width = 32;
    default: width = 8;
  endcase
  if (is_mask) begin
    for (int i = 0; i < `VLEN; i++) begin
      data[i] = (i < vstart) ? vd[i] : tt[{vs2[i], vs1[i]}];
    end
  end else if (is_elem) begin
    // element e is active from vstart on, and when unmasked or v0[e] set
    for (int e = 0; e < `VLEN / width; e++) begin
      for (int k = 0; k < width; k++) begin
        idx       = e * width + k;
        data[idx] = (e >= vstart && (vm || v0[e])) ? tt[{vs2[idx], vs1[idx]}] : vd[idx];
      end
    end
  end
  return {rob_entry, is_mask | is_elem, is_mask, data};
endfunction

`endif

// File: verif/tb_rvv_alu.sv
`include "rvv_alu_macros.svh"

module tb_rvv_alu
  import rvv_alu_pkg::*;
();

  localparam int LIMIT = 200;

  logic                        clk;
  logic                        rst_n;
  logic                        uop_valid;
  logic [`ROB_DEPTH_WIDTH-1:0] uop_rob_entry;
  funct3_e                     uop_funct3;
  funct6_e                     uop_funct6;
  logic                        uop_vm;
  logic [`VLEN-1:0]            uop_v0_data;
  logic [`VLEN-1:0]            uop_vd_data;
  logic [`VLEN-1:0]            uop_vs1_data;
  logic [`VLEN-1:0]            uop_vs2_data;
  logic                        csr_write;
  logic [`VSTART_WIDTH-1:0]    csr_vstart;
  vsew_e                       csr_vsew;
  logic                        rs_full;
  logic                        result_valid;
  logic [`ROB_DEPTH_WIDTH-1:0] result_rob_entry;
  logic [`VLEN-1:0]            result_w_data;
  logic                        result_w_valid;
  logic                        result_ignore_vta;

  `include "tb_rvv_alu_ref.svh"

  logic [31:0]                 lfsr_state;
  int                          tb_vstart;
  vsew_e                       tb_vsew;
  logic [`ROB_DEPTH_WIDTH-1:0] next_tag;
  logic [EXP_W-1:0]            exp_q[$];
  string                       name_q[$];

  rvv_alu_top dut (.*);

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  function automatic logic [`VLEN-1:0] rand_bits(input int n);
    logic [`VLEN-1:0] bits;
    bits = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      bits[i]    = lfsr_state[0];
    end
    return bits;
  endfunction

  // codes 11 to 15 map to an opcode neither unit supports
  function automatic funct6_e pick_op(input logic [3:0] sel);
    case (sel)
      4'd0:    return VMANDN;
      4'd1:    return VMAND;
      4'd2:    return VMOR;
      4'd3:    return VMXOR;
      4'd4:    return VMORN;
      4'd5:    return VMNAND;
      4'd6:    return VMNOR;
      4'd7:    return VMXNOR;
      4'd8:    return VAND;
      4'd9:    return VOR;
      4'd10:   return VXOR;
      default: return funct6_e'(6'b000000);
    endcase
  endfunction

  task automatic abort_run();
    $display("Simulation FAILED");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [`VLEN-1:0] expected,
                             input logic [`VLEN-1:0] actual);
    if (expected !== actual) begin
      $display("ERROR %s expected %h actual %h", name, expected, actual);
      abort_run();
    end
  endtask

  task automatic wait_not_full();
    int cycles;
    cycles = 0;
    while (rs_full) begin
      @(negedge clk);
      cycles++;
      if (cycles > LIMIT) begin
        $display("timeout while waiting for rs_full to fall");
        abort_run();
      end
    end
  endtask

  task automatic drain_results();
    int cycles;
    cycles = 0;
    while (exp_q.size() != 0) begin
      @(negedge clk);
      cycles++;
      if (cycles > LIMIT) begin
        $display("timeout with %0d results still outstanding", exp_q.size());
        abort_run();
      end
    end
  endtask

  // queue and pipeline are idle when this runs
  task automatic write_config(input int vstart, input vsew_e sew);
    drain_results();
    csr_write  = 1'b1;
    csr_vstart = `VSTART_WIDTH'(vstart);
    csr_vsew   = sew;
    tb_vstart  = vstart;
    tb_vsew    = sew;
    @(negedge clk);
    csr_write = 1'b0;
  endtask

  task automatic send_uop(input string name, input funct3_e f3, input funct6_e f6,
                          input logic vm);
    wait_not_full();
    uop_valid     = 1'b1;
    uop_rob_entry = next_tag;
    uop_funct3    = f3;
    uop_funct6    = f6;
    uop_vm        = vm;
    uop_v0_data   = rand_bits(`VLEN);
    uop_vd_data   = rand_bits(`VLEN);
    uop_vs1_data  = rand_bits(`VLEN);
    uop_vs2_data  = rand_bits(`VLEN);
    exp_q.push_back(expected_result(next_tag, f3, f6, vm, uop_v0_data, uop_vd_data,
                                    uop_vs1_data, uop_vs2_data, tb_vstart, tb_vsew));
    name_q.push_back(name);
    // a written vstart covers only the next uop
    tb_vstart = 0;
    next_tag  = next_tag + 1'b1;
    @(negedge clk);
    uop_valid = 1'b0;
  endtask

  // results are compared mid-cycle where the registered outputs are stable
  always @(negedge clk) begin
    logic [EXP_W-1:0] expect_word;
    string            name;
    if (rst_n && result_valid) begin
      if (exp_q.size() == 0) begin
        $display("result with tag %0d arrived with no uop outstanding", result_rob_entry);
        abort_run();
      end else begin
        expect_word = exp_q.pop_front();
        name        = name_q.pop_front();
        check_value({name, " rob_entry"}, `VLEN'(expect_word[EXP_W-1 -: `ROB_DEPTH_WIDTH]),
                    `VLEN'(result_rob_entry));
        check_value({name, " w_valid"}, `VLEN'(expect_word[`VLEN+1]), `VLEN'(result_w_valid));
        check_value({name, " ignore_vta"}, `VLEN'(expect_word[`VLEN]),
                    `VLEN'(result_ignore_vta));
        check_value({name, " w_data"}, expect_word[`VLEN-1:0], result_w_data);
      end
    end
  end

  initial begin
    funct6_e          op;
    funct3_e          f3;
    vsew_e            sew;
    logic [`VLEN-1:0] r;
    rst_n         = 1'b0;
    uop_valid     = 1'b0;
    uop_rob_entry = '0;
    uop_funct3    = OPIVV;
    uop_funct6    = VAND;
    uop_vm        = 1'b0;
    uop_v0_data   = '0;
    uop_vd_data   = '0;
    uop_vs1_data  = '0;
    uop_vs2_data  = '0;
    csr_write     = 1'b0;
    csr_vstart    = '0;
    csr_vsew      = SEW8;
    lfsr_state    = 32'he2bd;
    tb_vstart     = 0;
    tb_vsew       = SEW8;
    next_tag      = '0;
    repeat (2) @(negedge clk);
    rst_n = 1'b1;
    check_value("after reset rs_full", '0, `VLEN'(rs_full));
    check_value("after reset result_valid", '0, `VLEN'(result_valid));

    // every mask-register op, unmasked, vstart 0
    op = VMANDN;
    repeat (8) begin
      send_uop($sformatf("mask %s", op.name()), OPMVV, op, 1'b1);
      op = op.next();
    end

    // prefix below vstart keeps vd, then vstart is back to 0
    write_config(37, SEW8);
    send_uop("mask vstart 37", OPMVV, VMXOR, 1'b1);
    send_uop("mask after vstart", OPMVV, VMAND, 1'b1);

    // element logic at each width, masked and unmasked
    for (int s = 0; s < 3; s++) begin
      sew = (s == 0) ? SEW8 : (s == 1) ? SEW16 : SEW32;
      write_config(0, sew);
      op = VAND;
      repeat (3) begin
        send_uop($sformatf("%s %s vm0", op.name(), sew.name()), OPIVV, op, 1'b0);
        send_uop($sformatf("%s %s vm1", op.name(), sew.name()), OPIVV, op, 1'b1);
        op = op.next();
      end
    end
    write_config(5, SEW16);
    send_uop("vor sew16 vstart 5", OPIVV, VOR, 1'b0);

    // uops that retire without a register write
    send_uop("mask vm low", OPMVV, VMNOR, 1'b0);
    send_uop("unsupported funct6", OPIVV, funct6_e'(6'b000000), 1'b1);
    send_uop("logic code as opmvv", OPMVV, VOR, 1'b1);

    // back-to-back random burst
    repeat (40) begin
      r  = rand_bits(7);
      f3 = (r[3:0] < 4'd8) ? OPMVV : OPIVV;
      if (r[4] && r[5]) begin
        f3 = (f3 == OPMVV) ? OPIVV : OPMVV;
      end
      send_uop("burst", f3, pick_op(r[3:0]), r[6]);
    end

    drain_results();
    // any stray result beyond the last uop would arrive within the queue depth
    repeat (`RS_DEPTH + 2) @(negedge clk);
    $display("Simulation PASSED");
    $finish;
  end

endmodule

// File: filelist.f
+incdir+hdl
+incdir+verif
hdl/rvv_alu_pkg.sv
hdl/rvv_alu_csr.sv
hdl/rvv_alu_rs.sv
hdl/rvv_alu_unit_mask.sv
hdl/rvv_alu_unit_logic.sv
hdl/rvv_alu_rob_wb.sv
hdl/rvv_alu_top.sv
verif/tb_rvv_alu.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the rvv alu testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f filelist.f --top-module tb_rvv_alu \
  -Mdir obj_dir -o tb_rvv_alu
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit 1
fi

./obj_dir/tb_rvv_alu
status=$?
if [ $status -ne 0 ]; then
  echo "simulation failed with status $status"
  exit $status
fi

echo "simulation finished cleanly"
exit 0
